// File: logic/pep_geom_pkg.sv
package pep_geom_pkg;

  // ==========================================================
  // Batch geometry
  // ==========================================================

  // Ciphertext slots in one batch
  localparam int BATCH_PBS_NB = 8;

  // Slot index, enough to address every slot
  localparam int BPBS_ID_W    = $clog2(BATCH_PBS_NB);
  // Ciphertext count, up to a full batch
  localparam int BPBS_NB_W    = $clog2(BATCH_PBS_NB + 1);

  // Blind-rotation loop index
  localparam int BR_LOOP_W    = 10;
  // Ciphertext identifier
  localparam int CT_ID_W      = 8;

  // ==========================================================
  // Vector types
  // ==========================================================

  // Position inside the slot map
  typedef logic [BPBS_ID_W-1:0] bpbs_id_t;
  // Count of ciphertexts, also used for count minus one
  typedef logic [BPBS_NB_W-1:0] bpbs_nb_t;
  typedef logic [BR_LOOP_W-1:0] br_loop_t;
  typedef logic [CT_ID_W-1:0]   ct_id_t;

endpackage

// File: logic/pep_cmd_pkg.sv
package pep_cmd_pkg;

  import pep_geom_pkg::*;

  // ==========================================================
  // Sequencer command
  // ==========================================================

  // One slot of the batch map
  typedef struct packed {
    // Slot holds a ciphertext to process
    logic   avail;
    ct_id_t ct_id;
  } map_elt_t;

  // Batch command pushed by the sequencer
  typedef struct packed {
    // Flush only, no slot processed
    logic                        is_flush;
    br_loop_t                    br_loop;
    // Number of available slots minus one
    bpbs_nb_t                    ct_nb_m1;
    // Slot 0 sits in the low bits
    map_elt_t [BATCH_PBS_NB-1:0] map;
  } pbs_cmd_t;

  // ==========================================================
  // Feed command toward the GLWE RAM partitions
  // ==========================================================

  typedef struct packed {
    logic     is_flush;
    // First and last ciphertext of the batch
    logic     batch_first_ct;
    logic     batch_last_ct;
    // Rank among the available ciphertexts
    bpbs_nb_t pbs_id;
    br_loop_t br_loop;
    map_elt_t map_elt;
    // Slot position in the map
    bpbs_id_t map_idx;
    bpbs_nb_t ct_nb_m1;
  } mmacc_feed_cmd_t;

  // Flattened widths
  localparam int PBS_CMD_W        = $bits(pbs_cmd_t);
  localparam int MMACC_FEED_CMD_W = $bits(mmacc_feed_cmd_t);

endpackage

// File: logic/pep_cmd_fifo.sv
`timescale 1ns/1ps

module pep_cmd_fifo
  import pep_cmd_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic     clk,
  input  logic     s_rst_n,

  // Write side
  input  pbs_cmd_t in_cmd,
  input  logic     in_vld,
  output logic     in_rdy,

  // Read side
  output pbs_cmd_t out_cmd,
  output logic     out_vld,
  input  logic     out_rdy
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);

  // ==========================================================
  // Storage
  // ==========================================================

  logic [PBS_CMD_W-1:0] mem [DEPTH];

  logic [ADDR_W-1:0]    wr_ptr;
  logic [ADDR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]     count;

  logic                 full;
  logic                 push;
  logic                 pop;

  assign full    = count == CNT_W'(DEPTH);
  assign out_vld = count != '0;
  // Head slot is read straight from the storage registers
  assign out_cmd = mem[rd_ptr];

  // When full, a pop in the same cycle frees a slot for the push
  assign in_rdy  = ~full | out_rdy;
  assign push    = in_vld & in_rdy;
  assign pop     = out_vld & out_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_cmd;
    end
  end

  // ==========================================================
  // Pointers and occupancy
  // ==========================================================

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Circular wrap at DEPTH entries
      if (push) begin
        wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Count unchanged on push and pop together
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: logic/pep_cmd_pipe_buffer.sv
`timescale 1ns/1ps

module pep_cmd_pipe_buffer
  import pep_cmd_pkg::*;
(
  input  logic            clk,
  input  logic            s_rst_n,

  // Upstream side, from the fork
  input  mmacc_feed_cmd_t in_mcmd,
  input  logic            in_vld,
  output logic            in_rdy,

  // Downstream side, toward the partition
  output mmacc_feed_cmd_t out_mcmd,
  output logic            out_vld,
  input  logic            out_rdy
);

  // Second entry, used only when the output is stalled
  logic [MMACC_FEED_CMD_W-1:0] skid_mcmd;
  logic                        skid_vld;

  logic                        in_xfer;
  logic                        out_free;

  // Ready comes from a register, so no path from out_rdy
  assign in_rdy   = ~skid_vld;
  assign in_xfer  = in_vld & in_rdy;
  // Output register empty or emptied this cycle
  assign out_free = ~out_vld | out_rdy;

  // ==========================================================
  // Control
  // ==========================================================

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_vld  <= 1'b0;
      skid_vld <= 1'b0;
    end else begin
      if (out_free) begin
        // Skid entry is older, drain it first
        out_vld  <= skid_vld | in_xfer;
        skid_vld <= 1'b0;
      end else if (in_xfer) begin
        skid_vld <= 1'b1;
      end
    end
  end

  // ==========================================================
  // Payload
  // ==========================================================

  always_ff @(posedge clk) begin
    if (out_free) begin
      if (skid_vld) begin
        out_mcmd <= skid_mcmd;
      end else if (in_xfer) begin
        out_mcmd <= in_mcmd;
      end
    end else if (in_xfer) begin
      skid_mcmd <= in_mcmd;
    end
  end

endmodule

// File: logic/pep_mmacc_feed_entry.sv
`timescale 1ns/1ps

module pep_mmacc_feed_entry
  import pep_geom_pkg::*;
  import pep_cmd_pkg::*;
#(
  parameter int LWE_K = 6
) (
  input  logic            clk,
  input  logic            s_rst_n,

  // Command from the FIFO
  input  pbs_cmd_t        ffifo_pcmd,
  input  logic            ffifo_vld,
  output logic            ffifo_rdy,

  // Main partition
  output mmacc_feed_cmd_t main_mcmd,
  output logic            main_vld,
  input  logic            main_rdy,

  // Subsidiary partition
  output mmacc_feed_cmd_t subs_mcmd,
  output logic            subs_vld,
  input  logic            subs_rdy,

  // Key loader status and cache clear
  input  logic            inc_bsk_wr_ptr,
  input  logic            reset_cache
);

  localparam int LWE_K_W = (LWE_K > 1) ? $clog2(LWE_K) : 1;

  // ==========================================================
  // Input pulse registers
  // ==========================================================

  logic in_inc_bsk_wr_ptr;
  logic reset_loop;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      in_inc_bsk_wr_ptr <= 1'b0;
      reset_loop        <= 1'b0;
    end else begin
      in_inc_bsk_wr_ptr <= inc_bsk_wr_ptr;
      reset_loop        <= reset_cache;
    end
  end

  // ==========================================================
  // Key slice tracking
  // ==========================================================

  // MSB is the wrap bit
  logic [LWE_K_W:0] bsk_wp;
  logic [LWE_K_W:0] bsk_rp;
  logic             bsk_wp_last;
  logic             bsk_rp_last;
  logic             bsk_empty;
  logic             bsk_full;
  logic             bsk_rd_done;
  logic             bsk_wr_ok;

  assign bsk_wp_last = bsk_wp[LWE_K_W-1:0] == LWE_K_W'(LWE_K - 1);
  assign bsk_rp_last = bsk_rp[LWE_K_W-1:0] == LWE_K_W'(LWE_K - 1);

  // Same index, wrap bits equal when empty, different when full
  assign bsk_empty = bsk_wp == bsk_rp;
  assign bsk_full  = (bsk_wp[LWE_K_W-1:0] == bsk_rp[LWE_K_W-1:0])
                   & (bsk_wp[LWE_K_W] != bsk_rp[LWE_K_W]);
  // Extra write pulse on a full buffer is dropped
  assign bsk_wr_ok = in_inc_bsk_wr_ptr & ~bsk_full;

  always_ff @(posedge clk) begin
    if (!s_rst_n || reset_loop) begin
      bsk_wp <= '0;
      bsk_rp <= '0;
    end else begin
      // Toggle wrap bit and restart index after the last slice
      if (bsk_wr_ok) begin
        bsk_wp <= bsk_wp_last ? {~bsk_wp[LWE_K_W], {LWE_K_W{1'b0}}} : bsk_wp + 1'b1;
      end
      if (bsk_rd_done) begin
        bsk_rp <= bsk_rp_last ? {~bsk_rp[LWE_K_W], {LWE_K_W{1'b0}}} : bsk_rp + 1'b1;
      end
    end
  end

  // ==========================================================
  // Slot map walk
  // ==========================================================

  map_elt_t [BATCH_PBS_NB-1:0] fm_map;
  map_elt_t                    fm_map_elt;
  bpbs_id_t                    fm_map_idx;
  bpbs_nb_t                    fm_pbs_cnt;
  logic                        fm_first;
  logic                        fm_last;

  logic                        fm_proc_ok;
  logic                        fm_flush_ok;
  logic                        fm_do_proc;
  logic                        fm_do_bypass;
  logic                        fm_vld;
  logic                        fm_rdy;

  assign fm_map     = ffifo_pcmd.map;
  assign fm_map_elt = fm_map[fm_map_idx];
  assign fm_first   = fm_pbs_cnt == '0;
  assign fm_last    = fm_pbs_cnt == ffifo_pcmd.ct_nb_m1;

  // Available slot needs a key slice
  assign fm_proc_ok   = ~bsk_empty & ~ffifo_pcmd.is_flush & fm_map_elt.avail;
  // Flush goes out with a key, or right on a cache reset
  assign fm_flush_ok  = ffifo_pcmd.is_flush & (~bsk_empty | reset_loop);

  assign fm_do_proc   = ffifo_vld & fm_proc_ok & fm_rdy;
  // Empty slot skipped, no output and no key needed
  assign fm_do_bypass = ffifo_vld & ~fm_map_elt.avail & ~ffifo_pcmd.is_flush;

  assign fm_vld    = ffifo_vld & (fm_proc_ok | fm_flush_ok);
  // Pop with the last ciphertext or with the flush
  assign ffifo_rdy = fm_rdy & ((fm_proc_ok & fm_last) | fm_flush_ok);

  // One key slice consumed per completed command
  assign bsk_rd_done = ffifo_vld & ffifo_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      fm_map_idx <= '0;
      fm_pbs_cnt <= '0;
    end else begin
      if (fm_do_proc && fm_last) begin
        // Command done, restart for the next one
        fm_map_idx <= '0;
        fm_pbs_cnt <= '0;
      end else if (fm_do_proc) begin
        fm_map_idx <= fm_map_idx + 1'b1;
        fm_pbs_cnt <= fm_pbs_cnt + 1'b1;
      end else if (fm_do_bypass) begin
        fm_map_idx <= fm_map_idx + 1'b1;
      end
    end
  end

  // ==========================================================
  // Fork to main and subsidiary
  // ==========================================================

  mmacc_feed_cmd_t fm_mcmd;
  logic            fm_main_vld;
  logic            fm_main_rdy;
  logic            fm_subs_vld;
  logic            fm_subs_rdy;

  assign fm_mcmd.is_flush       = ffifo_pcmd.is_flush;
  assign fm_mcmd.batch_first_ct = fm_first;
  assign fm_mcmd.batch_last_ct  = fm_last;
  assign fm_mcmd.pbs_id         = fm_pbs_cnt;
  assign fm_mcmd.br_loop        = ffifo_pcmd.br_loop;
  assign fm_mcmd.map_elt        = fm_map_elt;
  assign fm_mcmd.map_idx        = fm_map_idx;
  assign fm_mcmd.ct_nb_m1       = ffifo_pcmd.ct_nb_m1;

  // Each branch waits for the other, both take or neither
  assign fm_main_vld = fm_vld & fm_subs_rdy;
  assign fm_subs_vld = fm_vld & fm_main_rdy;
  assign fm_rdy      = fm_main_rdy & fm_subs_rdy;

  pep_cmd_pipe_buffer u_main_buf (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_mcmd  (fm_mcmd),
    .in_vld   (fm_main_vld),
    .in_rdy   (fm_main_rdy),
    .out_mcmd (main_mcmd),
    .out_vld  (main_vld),
    .out_rdy  (main_rdy)
  );

  pep_cmd_pipe_buffer u_subs_buf (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_mcmd  (fm_mcmd),
    .in_vld   (fm_subs_vld),
    .in_rdy   (fm_subs_rdy),
    .out_mcmd (subs_mcmd),
    .out_vld  (subs_vld),
    .out_rdy  (subs_rdy)
  );

endmodule

// File: logic/pep_mmacc_feed_top.sv
`timescale 1ns/1ps

module pep_mmacc_feed_top
  import pep_cmd_pkg::*;
#(
  parameter int LWE_K          = 6,
  parameter int CMD_FIFO_DEPTH = 4
) (
  input  logic            clk,
  input  logic            s_rst_n,

  // Sequencer commands
  input  pbs_cmd_t        seq_cmd,
  input  logic            seq_vld,
  output logic            seq_rdy,

  // Feed commands to the two GLWE RAM partitions
  output mmacc_feed_cmd_t main_mcmd,
  output logic            main_vld,
  input  logic            main_rdy,
  output mmacc_feed_cmd_t subs_mcmd,
  output logic            subs_vld,
  input  logic            subs_rdy,

  // Key loader write pulse and cache clear
  input  logic            inc_bsk_wr_ptr,
  input  logic            reset_cache
);

  // FIFO head toward the feed entry
  pbs_cmd_t ffifo_pcmd;
  logic     ffifo_vld;
  logic     ffifo_rdy;

  pep_cmd_fifo #(
    .DEPTH (CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .in_cmd  (seq_cmd),
    .in_vld  (seq_vld),
    .in_rdy  (seq_rdy),
    .out_cmd (ffifo_pcmd),
    .out_vld (ffifo_vld),
    .out_rdy (ffifo_rdy)
  );

  pep_mmacc_feed_entry #(
    .LWE_K (LWE_K)
  ) u_feed_entry (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .ffifo_pcmd     (ffifo_pcmd),
    .ffifo_vld      (ffifo_vld),
    .ffifo_rdy      (ffifo_rdy),
    .main_mcmd      (main_mcmd),
    .main_vld       (main_vld),
    .main_rdy       (main_rdy),
    .subs_mcmd      (subs_mcmd),
    .subs_vld       (subs_vld),
    .subs_rdy       (subs_rdy),
    .inc_bsk_wr_ptr (inc_bsk_wr_ptr),
    .reset_cache    (reset_cache)
  );

endmodule

// File: bench/tb_feed_entry.sv
`timescale 1ns/1ps

module tb_feed_entry
  import pep_geom_pkg::*;
  import pep_cmd_pkg::*;
();

  localparam int LWE_K    = 6;
  localparam int N_CMDS   = 22;
  localparam int RDY_HIGH = 0;
  localparam int RDY_LOW  = 1;
  localparam int RDY_RAND = 2;

  logic            clk = 1'b0;
  logic            s_rst_n;
  pbs_cmd_t        seq_cmd;
  logic            seq_vld;
  logic            seq_rdy;
  mmacc_feed_cmd_t main_mcmd;
  logic            main_vld;
  logic            main_rdy;
  mmacc_feed_cmd_t subs_mcmd;
  logic            subs_vld;
  logic            subs_rdy;
  logic            inc_bsk_wr_ptr;
  logic            reset_cache;

  // One expected feed command queue per partition
  mmacc_feed_cmd_t exp_main[$];
  mmacc_feed_cmd_t exp_subs[$];
  string           cur_test;
  int              test_errs;
  int              pass_tests;
  int              fail_tests;
  int              main_xfers;
  int              subs_xfers;
  int              done_cnt;
  int              rdy_mode;
  logic [31:0]     seed_val;

  always #2 clk = ~clk;

  pep_mmacc_feed_top #(.LWE_K(LWE_K), .CMD_FIFO_DEPTH(4)) u_dut (
    .clk(clk), .s_rst_n(s_rst_n),
    .seq_cmd(seq_cmd), .seq_vld(seq_vld), .seq_rdy(seq_rdy),
    .main_mcmd(main_mcmd), .main_vld(main_vld), .main_rdy(main_rdy),
    .subs_mcmd(subs_mcmd), .subs_vld(subs_vld), .subs_rdy(subs_rdy),
    .inc_bsk_wr_ptr(inc_bsk_wr_ptr), .reset_cache(reset_cache)
  );

  // ============================================================
  // Checking and reporting
  // ============================================================

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Test %s: %s", cur_test, msg);
    test_errs++;
  endtask

  // Flush carries only its flag and loop index
  task automatic compare_feed(input string part, input mmacc_feed_cmd_t exp,
                              input mmacc_feed_cmd_t act);
    if (exp.is_flush) begin
      check_val({part, " flush"}, 64'({exp.is_flush, exp.br_loop}),
                64'({act.is_flush, act.br_loop}));
    end else begin
      check_val({part, " feed cmd"}, 64'(exp), 64'(act));
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      pass_tests++;
      $display("Test %s: ok", cur_test);
    end else begin
      fail_tests++;
      $display("Test %s: %0d errors", cur_test, test_errs);
    end
  endtask

  // ============================================================
  // Monitors sample on the rising edge before any register update
  // ============================================================

  always @(posedge clk) begin
    if (s_rst_n && main_vld && main_rdy) begin
      main_xfers++;
      if (main_mcmd.batch_last_ct || main_mcmd.is_flush) begin
        done_cnt++;
      end
      if (exp_main.size() == 0) begin
        report_failure("main partition sent an unexpected feed command");
      end else begin
        compare_feed("main", exp_main.pop_front(), main_mcmd);
      end
    end
  end

  always @(posedge clk) begin
    if (s_rst_n && subs_vld && subs_rdy) begin
      subs_xfers++;
      if (exp_subs.size() == 0) begin
        report_failure("subs partition sent an unexpected feed command");
      end else begin
        compare_feed("subs", exp_subs.pop_front(), subs_mcmd);
      end
    end
  end

  // Partition ready per test mode
  always @(negedge clk) begin : rdy_drive
    logic [31:0] r;
    r = $urandom;
    case (rdy_mode)
      RDY_LOW: begin
        main_rdy = 1'b0;
        subs_rdy = 1'b0;
      end
      RDY_RAND: begin
        main_rdy = r[0];
        subs_rdy = r[1];
      end
      default: begin
        main_rdy = 1'b1;
        subs_rdy = 1'b1;
      end
    endcase
  end

  // ============================================================
  // Stimulus and reference model
  // ============================================================

  function automatic logic [BATCH_PBS_NB-1:0] random_mask();
    logic [31:0] r;
    r = $urandom;
    // At least one slot must hold a ciphertext
    return (r[BATCH_PBS_NB-1:0] == '0) ? BATCH_PBS_NB'(1) : r[BATCH_PBS_NB-1:0];
  endfunction

  function automatic pbs_cmd_t make_cmd(input logic [BATCH_PBS_NB-1:0] mask, input logic flush);
    pbs_cmd_t    c;
    logic [31:0] r;
    int          n;
    c = '0;
    n = 0;
    r = $urandom;
    c.is_flush = flush;
    c.br_loop  = r[BR_LOOP_W-1:0];
    for (int i = 0; i < BATCH_PBS_NB; i++) begin
      r = $urandom;
      c.map[i].avail = mask[i] & ~flush;
      c.map[i].ct_id = r[CT_ID_W-1:0];
      if (mask[i] && !flush) n++;
    end
    c.ct_nb_m1 = flush ? '0 : bpbs_nb_t'(n - 1);
    return c;
  endfunction

  // One feed cmd per available slot in index order with ranks from zero
  task automatic expect_cmd(input pbs_cmd_t c);
    mmacc_feed_cmd_t e;
    int              rank;
    int              n_avail;
    rank    = 0;
    n_avail = 0;
    e       = '0;
    if (c.is_flush) begin
      e.is_flush = 1'b1;
      e.br_loop  = c.br_loop;
      exp_main.push_back(e);
      exp_subs.push_back(e);
    end else begin
      for (int i = 0; i < BATCH_PBS_NB; i++) begin
        if (c.map[i].avail) n_avail++;
      end
      for (int i = 0; i < BATCH_PBS_NB; i++) begin
        if (c.map[i].avail) begin
          e.batch_first_ct = rank == 0;
          e.batch_last_ct  = rank == n_avail - 1;
          e.pbs_id         = bpbs_nb_t'(rank);
          e.br_loop        = c.br_loop;
          e.map_elt        = c.map[i];
          e.map_idx        = bpbs_id_t'(i);
          e.ct_nb_m1       = c.ct_nb_m1;
          exp_main.push_back(e);
          exp_subs.push_back(e);
          rank++;
        end
      end
    end
  endtask

  // Ready checked on the falling edge, push on the next rising edge
  task automatic send_cmd(input pbs_cmd_t c);
    expect_cmd(c);
    @(negedge clk);
    seq_cmd = c;
    seq_vld = 1'b1;
    while (!seq_rdy) @(negedge clk);
    @(negedge clk);
    seq_vld = 1'b0;
  endtask

  task automatic pulse_key();
    @(negedge clk) inc_bsk_wr_ptr = 1'b1;
    @(negedge clk) inc_bsk_wr_ptr = 1'b0;
  endtask

  task automatic pulse_reset_cache();
    @(negedge clk) reset_cache = 1'b1;
    @(negedge clk) reset_cache = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while ((exp_main.size() != 0 || exp_subs.size() != 0) && t < 1000) begin
      @(negedge clk);
      t++;
    end
    if (exp_main.size() != 0 || exp_subs.size() != 0) begin
      report_failure("expected feed commands never arrived");
    end
    wait_cycles(4);
  endtask

  // ============================================================
  // Watchdog
  // ============================================================

  initial begin
    repeat (200 * N_CMDS + 2000) @(posedge clk);
    $display("Run stopped by the watchdog, the tests did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  // ============================================================
  // Directed tests
  // ============================================================

  initial begin
    int base;
    seed_val       = $urandom(76);
    s_rst_n        = 1'b0;
    seq_cmd        = '0;
    seq_vld        = 1'b0;
    main_rdy       = 1'b1;
    subs_rdy       = 1'b1;
    inc_bsk_wr_ptr = 1'b0;
    reset_cache    = 1'b0;
    rdy_mode       = RDY_HIGH;
    main_xfers     = 0;
    subs_xfers     = 0;
    done_cnt       = 0;
    pass_tests     = 0;
    fail_tests     = 0;
    repeat (16) @(posedge clk);
    @(negedge clk) s_rst_n = 1'b1;

    // Nothing moves without a key
    start_test("key_gating");
    check_val("seq_rdy after reset", 64'(1), 64'(seq_rdy));
    base = main_xfers + subs_xfers;
    send_cmd(make_cmd(random_mask(), 1'b0));
    wait_cycles(50);
    check_val("transfers without key", 64'(base), 64'(main_xfers + subs_xfers));
    pulse_key();
    wait_drain();
    end_test();

    start_test("map_walk");
    repeat (4) pulse_key();
    repeat (4) send_cmd(make_cmd(random_mask(), 1'b0));
    wait_drain();
    end_test();

    // One command more than keys so the last one waits
    start_test("key_consumption");
    base = done_cnt;
    repeat (LWE_K) pulse_key();
    repeat (LWE_K + 1) send_cmd(make_cmd(random_mask(), 1'b0));
    for (int t = 0; t < 1000 && done_cnt < base + LWE_K; t++) @(negedge clk);
    wait_cycles(50);
    check_val("completed commands", 64'(base + LWE_K), 64'(done_cnt));
    pulse_key();
    wait_drain();
    check_val("completed commands", 64'(base + LWE_K + 1), 64'(done_cnt));
    end_test();

    start_test("flush");
    pulse_key();
    send_cmd(make_cmd('0, 1'b1));
    wait_drain();
    // Key taken by the flush
    base = main_xfers + subs_xfers;
    send_cmd(make_cmd(random_mask(), 1'b0));
    wait_cycles(50);
    check_val("transfers after flush", 64'(base), 64'(main_xfers + subs_xfers));
    pulse_key();
    wait_drain();
    base = main_xfers + subs_xfers;
    send_cmd(make_cmd('0, 1'b1));
    wait_cycles(30);
    check_val("flush without key", 64'(base), 64'(main_xfers + subs_xfers));
    pulse_reset_cache();
    wait_drain();
    end_test();

    // Full first command stalls the head and the FIFO fills
    start_test("back_pressure");
    rdy_mode = RDY_LOW;
    repeat (LWE_K) pulse_key();
    send_cmd(make_cmd('1, 1'b0));
    repeat (3) send_cmd(make_cmd(random_mask(), 1'b0));
    wait_cycles(2);
    check_val("seq_rdy with FIFO full", 64'(0), 64'(seq_rdy));
    rdy_mode = RDY_RAND;
    repeat (2) send_cmd(make_cmd(random_mask(), 1'b0));
    wait_drain();
    rdy_mode = RDY_HIGH;
    wait_cycles(4);
    end_test();

    start_test("cache_reset");
    repeat (3) pulse_key();
    wait_cycles(5);
    pulse_reset_cache();
    wait_cycles(3);
    base = main_xfers + subs_xfers;
    send_cmd(make_cmd(random_mask(), 1'b0));
    wait_cycles(50);
    check_val("transfers after cache reset", 64'(base), 64'(main_xfers + subs_xfers));
    pulse_key();
    wait_drain();
    end_test();

    $display("Tests: %0d ok, %0d with errors", pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim.f
logic/pep_geom_pkg.sv
logic/pep_cmd_pkg.sv
logic/pep_cmd_fifo.sv
logic/pep_cmd_pipe_buffer.sv
logic/pep_mmacc_feed_entry.sv
logic/pep_mmacc_feed_top.sv
bench/tb_feed_entry.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator and run the feed entry testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_feed_entry \
  -f sim.f \
  -Mdir obj_dir -o tb_feed_entry

./obj_dir/tb_feed_entry | tee sim.log

if grep -q "Simulation passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
